//--- noc_access_guard.f
noc_guard_pkg.sv
addr_req_if.sv
addr_slot.sv
access_policy.sv
intrusion_log.sv
noc_access_guard.sv
noc_access_guard_tb.sv

//--- noc_access_guard_tb.sv
// Testbench for the access guard, directed cases then seeded random traffic
// A model predicts forwards, denials and the log, concurrent assertions compare

`timescale 1ns/1ps

module noc_access_guard_tb;
	import noc_guard_pkg::*;

	localparam int unsigned MAX_LEN = 0;	// Burst limits of the default DUT
	localparam int unsigned MAX_SIZE = 2;
	localparam int unsigned MY_BIT = 2 * 4 + 1;	// myx times side plus myy
	localparam int DIRECTED_CYCLES = 100;
	localparam int RANDOM_REQS = 200;
	localparam longint TIMEOUT_NS = (DIRECTED_CYCLES + RANDOM_REQS * 20) * 100;

	typedef struct packed {
		logic [31:0] addr;
		len_t        len;
		size_t       size;
		id_t         id;
	} req_t;

	logic COUNTER_INTRUSION_DETECTED = 1'b0;
	logic rst_n;
	logic aw_valid, ar_valid, aw_ready, ar_ready;
	logic fwd_aw_valid, fwd_ar_valid, fwd_aw_ready, fwd_ar_ready;
	logic [31:0] aw_addr, ar_addr, fwd_aw_addr, fwd_ar_addr;
	len_t aw_len, ar_len, fwd_aw_len, fwd_ar_len;
	size_t aw_size, ar_size, fwd_aw_size, fwd_ar_size;
	id_t aw_id, ar_id, fwd_aw_id, fwd_ar_id;
	logic [15:0] intrusion_flags;
	logic [DENY_CNT_WIDTH-1:0] deny_count;

	req_t aw_q[$];	// Expected forwards, write side
	req_t ar_q[$];	// Expected forwards, read side
	req_t aw_head, ar_head, w, rd;
	logic aw_pending, ar_pending, aw_deny_pend, ar_deny_pend;
	logic aw_free, ar_free;	// Model slot empty, expected upstream ready
	logic random_ready, w_en, r_en;
	logic [15:0] exp_flags;
	int exp_count, deny_n;
	integer seed = 2;
	logic [31:0] r;

	noc_access_guard dut_i (.COUNTER_INTRUSION_DETECTED(COUNTER_INTRUSION_DETECTED),
		.rst_n(rst_n), .myx(2'd2), .myy(2'd1),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr), .aw_len(aw_len),
		.aw_size(aw_size), .aw_id(aw_id),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr), .ar_len(ar_len),
		.ar_size(ar_size), .ar_id(ar_id),
		.fwd_aw_valid(fwd_aw_valid), .fwd_aw_ready(fwd_aw_ready), .fwd_aw_addr(fwd_aw_addr),
		.fwd_aw_len(fwd_aw_len), .fwd_aw_size(fwd_aw_size), .fwd_aw_id(fwd_aw_id),
		.fwd_ar_valid(fwd_ar_valid), .fwd_ar_ready(fwd_ar_ready), .fwd_ar_addr(fwd_ar_addr),
		.fwd_ar_len(fwd_ar_len), .fwd_ar_size(fwd_ar_size), .fwd_ar_id(fwd_ar_id),
		.intrusion_flags(intrusion_flags), .deny_count(deny_count));

	always #50 COUNTER_INTRUSION_DETECTED = ~COUNTER_INTRUSION_DETECTED;	// 100 ns period

	task automatic report_failure(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	// Region permission and burst shape, straight from the access rules
	function automatic logic expect_allow(input logic is_write, input req_t q);
		perm_t perm;
		logic shape_ok;
		perm = '0;
		case (q.addr[31:30])
			2'd2: perm.write_deny = 1'b1;	// Read-only region
			2'd3: perm = '1;	// Locked
			default: perm = '0;
		endcase
		shape_ok = (q.len <= MAX_LEN) && (q.size <= MAX_SIZE);
		return shape_ok && !(is_write ? perm.write_deny : perm.read_deny);
	endfunction

	function automatic req_t make_req(input logic [1:0] region, input logic [29:0] low,
		input len_t len, input size_t size, input id_t id);
		return '{addr: {region, low}, len: len, size: size, id: id};
	endfunction

	// Model state moves at the same edges as the DUT registers
	always @(posedge COUNTER_INTRUSION_DETECTED or negedge rst_n)
	begin
		if (!rst_n)
		begin
			aw_q.delete();
			ar_q.delete();
			{aw_deny_pend, ar_deny_pend, exp_flags} = '0;
			exp_count = 0;
		end
		else
		begin
			deny_n = aw_deny_pend + ar_deny_pend;	// Deny cycle ends here
			if (deny_n != 0)
			begin
				exp_flags[MY_BIT] = 1'b1;
				exp_count = (exp_count + deny_n > 255) ? 255 : exp_count + deny_n;
			end
			{aw_deny_pend, ar_deny_pend} = 2'b00;
			if (aw_pending && fwd_aw_ready)
				void'(aw_q.pop_front());	// Taken downstream
			if (ar_pending && fwd_ar_ready)
				void'(ar_q.pop_front());
			if (aw_valid && aw_free)	// Accepted only into an empty slot
			begin
				if (expect_allow(1'b1, {aw_addr, aw_len, aw_size, aw_id}))
					aw_q.push_back({aw_addr, aw_len, aw_size, aw_id});
				else
					aw_deny_pend = 1'b1;
			end
			if (ar_valid && ar_free)
			begin
				if (expect_allow(1'b0, {ar_addr, ar_len, ar_size, ar_id}))
					ar_q.push_back({ar_addr, ar_len, ar_size, ar_id});
				else
					ar_deny_pend = 1'b1;
			end
		end
		aw_pending = aw_q.size() != 0;
		ar_pending = ar_q.size() != 0;
		aw_free = !aw_pending && !aw_deny_pend;	// Full while forwarding or denying
		ar_free = !ar_pending && !ar_deny_pend;
		aw_head = aw_pending ? aw_q[0] : '0;
		ar_head = ar_pending ? ar_q[0] : '0;
	end

	a_reset_state: assert property (@(posedge COUNTER_INTRUSION_DETECTED) $rose(rst_n) |->
		aw_ready && ar_ready && !fwd_aw_valid && !fwd_ar_valid
		&& intrusion_flags == 0 && deny_count == 0)
		else report_failure("outputs not idle after reset");
	a_aw_ready: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		aw_ready == aw_free)
		else report_failure("aw_ready differs from expected slot state");
	a_ar_ready: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		ar_ready == ar_free)
		else report_failure("ar_ready differs from expected slot state");
	a_aw_fwd: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		fwd_aw_valid == aw_pending)
		else report_failure("fwd_aw_valid differs from expected write forward");
	a_ar_fwd: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		fwd_ar_valid == ar_pending)
		else report_failure("fwd_ar_valid differs from expected read forward");
	a_aw_fields: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		fwd_aw_valid |-> {fwd_aw_addr, fwd_aw_len, fwd_aw_size, fwd_aw_id} == aw_head)
		else report_failure("forwarded write fields wrong");
	a_ar_fields: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		fwd_ar_valid |-> {fwd_ar_addr, fwd_ar_len, fwd_ar_size, fwd_ar_id} == ar_head)
		else report_failure("forwarded read fields wrong");
	a_count: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		deny_count == exp_count)
		else report_failure("deny_count differs from model");
	a_flags: assert property (@(posedge COUNTER_INTRUSION_DETECTED) disable iff (!rst_n)
		intrusion_flags == exp_flags)
		else report_failure("intrusion_flags differs from model");

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the guard stopped accepting or forwarding requests");
		$display("Test failed");
		$fatal(1);
	end

	task automatic next_cycle();
		@(negedge COUNTER_INTRUSION_DETECTED);
		if (random_ready)
		begin
			fwd_aw_ready = ($random(seed) & 3) != 0;	// Stall one cycle in four
			fwd_ar_ready = ($random(seed) & 3) != 0;
		end
	endtask

	// Waits for the selected slots to be empty, then offers one beat each
	task automatic send_requests(input logic we, input req_t wq, input logic re, input req_t rq);
		while (!((!we || aw_ready) && (!re || ar_ready)))
			next_cycle();
		aw_valid = we;
		{aw_addr, aw_len, aw_size, aw_id} = wq;
		ar_valid = re;
		{ar_addr, ar_len, ar_size, ar_id} = rq;
		next_cycle();
		aw_valid = 1'b0;
		ar_valid = 1'b0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		{aw_valid, ar_valid, fwd_aw_ready, fwd_ar_ready, random_ready} = '0;
		{aw_addr, aw_len, aw_size, aw_id, ar_addr, ar_len, ar_size, ar_id} = '0;
		repeat (5) next_cycle();
		rst_n = 1'b1;
		next_cycle();
		// Allowed write and read held under back-pressure
		send_requests(1'b1, make_req(2'd0, 30'h1000, 0, 2, 4'h1),
			1'b1, make_req(2'd2, 30'h2040, 0, 2, 4'h2));
		repeat (4) next_cycle();
		{fwd_aw_ready, fwd_ar_ready} = 2'b11;
		next_cycle();
		send_requests(1'b1, make_req(2'd0, 30'h0100, 3, 2, 4'h3), 1'b0, '0);	// Too long
		send_requests(1'b1, make_req(2'd1, 30'h0200, 0, 5, 4'h4), 1'b0, '0);	// Too wide
		send_requests(1'b1, make_req(2'd2, 30'h0300, 0, 1, 4'h5), 1'b0, '0);
		send_requests(1'b1, make_req(2'd3, 30'h0400, 0, 0, 4'h6), 1'b0, '0);
		send_requests(1'b0, '0, 1'b1, make_req(2'd3, 30'h0500, 0, 2, 4'h7));
		send_requests(1'b1, make_req(2'd1, 30'h0600, 0, 2, 4'h8),
			1'b1, make_req(2'd0, 30'h0700, 0, 0, 4'h9));
		send_requests(1'b0, '0, 1'b1, make_req(2'd1, 30'h0800, 0, 1, 4'hA));
		// Same-edge denials on both channels
		send_requests(1'b1, make_req(2'd3, 30'h0900, 0, 2, 4'hB),
			1'b1, make_req(2'd3, 30'h0A00, 1, 2, 4'hC));
		repeat (3) next_cycle();
		random_ready = 1'b1;
		repeat (RANDOM_REQS)
		begin
			r = $random(seed);
			w_en = r[0] | r[1];	// Write, read or both
			r_en = r[1] | !r[0];
			w = make_req(r[3:2], $random(seed), r[4] ? 4'd0 : r[11:8], r[7:5], r[15:12]);
			rd = make_req(r[17:16], $random(seed), r[18] ? 4'd0 : r[22:19], r[25:23], r[29:26]);
			send_requests(w_en, w, r_en, rd);
		end
		random_ready = 1'b0;
		{fwd_aw_ready, fwd_ar_ready} = 2'b11;
		while (aw_pending || ar_pending || !aw_ready || !ar_ready)
			next_cycle();
		repeat (3) next_cycle();
		if (exp_count == 255)	// Random phase must reach saturation
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("The random traffic never drove the denial counter into saturation");
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

//--- noc_access_guard.sv
// Address-side access guard between an AXI master and the network interface
// Top level, parameters set here are passed to the slots, policy and log

`timescale 1ns/1ps

module noc_access_guard #(
	parameter int unsigned ADDR_WIDTH     = 32,	// AXI address width
	parameter int unsigned XY_WIDTH       = 2,	// Mesh coordinate width
	parameter int unsigned MAX_BURST_LEN  = 0,	// Burst length limit
	parameter int unsigned MAX_BURST_SIZE = 2	// Burst size limit
) (
	input  logic                                     COUNTER_INTRUSION_DETECTED,	// Clock
	input  logic                                     rst_n,
	input  logic [XY_WIDTH-1:0]                      myx,	// Mesh position
	input  logic [XY_WIDTH-1:0]                      myy,

	// Write address from the master
	input  logic                                     aw_valid,
	output logic                                     aw_ready,
	input  logic [ADDR_WIDTH-1:0]                    aw_addr,
	input  noc_guard_pkg::len_t                      aw_len,
	input  noc_guard_pkg::size_t                     aw_size,
	input  noc_guard_pkg::id_t                       aw_id,

	// Read address from the master
	input  logic                                     ar_valid,
	output logic                                     ar_ready,
	input  logic [ADDR_WIDTH-1:0]                    ar_addr,
	input  noc_guard_pkg::len_t                      ar_len,
	input  noc_guard_pkg::size_t                     ar_size,
	input  noc_guard_pkg::id_t                       ar_id,

	// Forwarded write address
	output logic                                     fwd_aw_valid,
	input  logic                                     fwd_aw_ready,
	output logic [ADDR_WIDTH-1:0]                    fwd_aw_addr,
	output noc_guard_pkg::len_t                      fwd_aw_len,
	output noc_guard_pkg::size_t                     fwd_aw_size,
	output noc_guard_pkg::id_t                       fwd_aw_id,

	// Forwarded read address
	output logic                                     fwd_ar_valid,
	input  logic                                     fwd_ar_ready,
	output logic [ADDR_WIDTH-1:0]                    fwd_ar_addr,
	output noc_guard_pkg::len_t                      fwd_ar_len,
	output noc_guard_pkg::size_t                     fwd_ar_size,
	output noc_guard_pkg::id_t                       fwd_ar_id,

	output logic [(1 << (2 * XY_WIDTH))-1:0]         intrusion_flags,	// Sticky per node
	output logic [noc_guard_pkg::DENY_CNT_WIDTH-1:0] deny_count	// Saturating
);

	logic wr_deny;	// Policy to log
	logic rd_deny;

	addr_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) wr_req ();	// Write slot to policy
	addr_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) rd_req ();	// Read slot to policy

	addr_slot #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) wr_slot_i (
		.clk       (COUNTER_INTRUSION_DETECTED),
		.rst_n     (rst_n),
		.in_valid  (aw_valid),
		.in_ready  (aw_ready),
		.in_addr   (aw_addr),
		.in_len    (aw_len),
		.in_size   (aw_size),
		.in_id     (aw_id),
		.req       (wr_req),
		.out_valid (fwd_aw_valid),
		.out_ready (fwd_aw_ready),
		.out_addr  (fwd_aw_addr),
		.out_len   (fwd_aw_len),
		.out_size  (fwd_aw_size),
		.out_id    (fwd_aw_id)
	);

	addr_slot #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) rd_slot_i (
		.clk       (COUNTER_INTRUSION_DETECTED),
		.rst_n     (rst_n),
		.in_valid  (ar_valid),
		.in_ready  (ar_ready),
		.in_addr   (ar_addr),
		.in_len    (ar_len),
		.in_size   (ar_size),
		.in_id     (ar_id),
		.req       (rd_req),
		.out_valid (fwd_ar_valid),
		.out_ready (fwd_ar_ready),
		.out_addr  (fwd_ar_addr),
		.out_len   (fwd_ar_len),
		.out_size  (fwd_ar_size),
		.out_id    (fwd_ar_id)
	);

	access_policy #(
		.ADDR_WIDTH     (ADDR_WIDTH),
		.MAX_BURST_LEN  (MAX_BURST_LEN),
		.MAX_BURST_SIZE (MAX_BURST_SIZE)
	) policy_i (
		.wr      (wr_req),
		.rd      (rd_req),
		.wr_deny (wr_deny),
		.rd_deny (rd_deny)
	);

	intrusion_log #(
		.XY_WIDTH (XY_WIDTH)
	) log_i (
		.clk             (COUNTER_INTRUSION_DETECTED),
		.rst_n           (rst_n),
		.myx             (myx),
		.myy             (myy),
		.wr_deny         (wr_deny),
		.rd_deny         (rd_deny),
		.intrusion_flags (intrusion_flags),
		.deny_count      (deny_count)
	);

endmodule

//--- intrusion_log.sv
// Sticky intrusion flag per mesh node and saturating denial counter
// Fed by the policy deny pulses, the node's own bit is picked by myx and myy

`timescale 1ns/1ps

module intrusion_log #(
	parameter int unsigned XY_WIDTH = 2	// Mesh coordinate width
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic [XY_WIDTH-1:0]                      myx,	// Node column
	input  logic [XY_WIDTH-1:0]                      myy,	// Node row
	input  logic                                     wr_deny,
	input  logic                                     rd_deny,
	output logic [(1 << (2 * XY_WIDTH))-1:0]         intrusion_flags,	// One bit per node
	output logic [noc_guard_pkg::DENY_CNT_WIDTH-1:0] deny_count
);
	import noc_guard_pkg::*;

	localparam int unsigned NODE_COUNT = 1 << (2 * XY_WIDTH);
	localparam logic [DENY_CNT_WIDTH-1:0] CNT_MAX = '1;	// Saturation value

	logic [2*XY_WIDTH-1:0]   node_idx;	// myx * side + myy
	logic [NODE_COUNT-1:0]   node_sel;	// One-hot of this node
	logic                    any_deny;
	logic [DENY_CNT_WIDTH:0] cnt_sum;	// One extra bit for overflow

	assign node_idx = {myx, myy};	// Concatenation is x times side plus y
	assign node_sel = NODE_COUNT'(1) << node_idx;
	assign any_deny = wr_deny || rd_deny;
	assign cnt_sum  = {1'b0, deny_count}
		+ (DENY_CNT_WIDTH + 1)'(wr_deny)
		+ (DENY_CNT_WIDTH + 1)'(rd_deny);	// Adds 0, 1 or 2

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			intrusion_flags <= '0;
			deny_count      <= '0;
		end
		else if (any_deny)
		begin
			intrusion_flags <= intrusion_flags | node_sel;	// Sticky until reset
			deny_count      <= (cnt_sum > {1'b0, CNT_MAX}) ? CNT_MAX
				: cnt_sum[DENY_CNT_WIDTH-1:0];
		end
	end

	a_cnt_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		1'b1 |=> deny_count >= $past(deny_count))
		else $error("intrusion_log: deny count went down");

endmodule

//--- access_policy.sv
// Burst-shape and region permission checks for the held write and read requests
// Pure combinational, gives allow to each slot and a deny pulse to the log

`timescale 1ns/1ps

module access_policy #(
	parameter int unsigned ADDR_WIDTH     = 32,	// Request address width
	parameter int unsigned MAX_BURST_LEN  = 0,	// Largest legal burst length
	parameter int unsigned MAX_BURST_SIZE = 2	// Largest legal size code
) (
	addr_req_if.policy wr,	// Held write address
	addr_req_if.policy rd,	// Held read address
	output logic       wr_deny,	// One pulse per denied write
	output logic       rd_deny	// One pulse per denied read
);
	import noc_guard_pkg::*;

	perm_t wr_perm;
	perm_t rd_perm;
	logic  wr_shape_ok;
	logic  rd_shape_ok;

	// Address permission unit, region from the top address bits
	function automatic perm_t region_perm(input logic [REGION_BITS-1:0] region);
		perm_t perm;
		perm = '0;
		case (region)
			REGION_OPEN0,
			REGION_OPEN1:  perm = '0;
			REGION_RDONLY: perm.write_deny = 1'b1;
			REGION_LOCKED:
			begin
				perm.write_deny = 1'b1;
				perm.read_deny  = 1'b1;
			end
		endcase
		return perm;
	endfunction

	// Intrusion check on burst length and size
	function automatic logic shape_ok(input len_t len, input size_t size);
		return (len <= MAX_BURST_LEN) && (size <= MAX_BURST_SIZE);
	endfunction

	assign wr_perm = region_perm(wr.addr[ADDR_WIDTH-1 -: REGION_BITS]);
	assign rd_perm = region_perm(rd.addr[ADDR_WIDTH-1 -: REGION_BITS]);

	assign wr_shape_ok = shape_ok(wr.len, wr.size);
	assign rd_shape_ok = shape_ok(rd.len, rd.size);

	assign wr.allow = wr_shape_ok && !wr_perm.write_deny;	// Both rules must pass
	assign rd.allow = rd_shape_ok && !rd_perm.read_deny;

	assign wr_deny = wr.full && !wr.allow;	// Lasts the single deny cycle
	assign rd_deny = rd.full && !rd.allow;

endmodule

//--- addr_slot.sv
// One-entry holding slot for an AXI address channel
// Forwards the held request when the policy allows it and drops it when denied

`timescale 1ns/1ps

module addr_slot #(
	parameter int unsigned ADDR_WIDTH = 32	// Request address width
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,	// Upstream address valid
	output logic                  in_ready,	// High while the slot is empty
	input  logic [ADDR_WIDTH-1:0] in_addr,
	input  noc_guard_pkg::len_t   in_len,
	input  noc_guard_pkg::size_t  in_size,
	input  noc_guard_pkg::id_t    in_id,
	addr_req_if.slot              req,	// To the policy
	output logic                  out_valid,	// Downstream address valid
	input  logic                  out_ready,
	output logic [ADDR_WIDTH-1:0] out_addr,
	output noc_guard_pkg::len_t   out_len,
	output noc_guard_pkg::size_t  out_size,
	output noc_guard_pkg::id_t    out_id
);
	import noc_guard_pkg::*;

	logic                  full_q;	// Slot occupied
	logic [ADDR_WIDTH-1:0] addr_q;
	len_t                  len_q;
	size_t                 size_q;
	id_t                   id_q;
	logic                  accept;	// Upstream handshake this cycle
	logic                  release_slot;	// Slot empties at this edge

	assign in_ready     = !full_q;
	assign accept       = in_valid && in_ready;
	assign out_valid    = full_q && req.allow;	// Only allowed requests go out
	assign release_slot = full_q && (!req.allow || out_ready);	// Dropped or taken

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			full_q <= 1'b0;
		else if (accept)
			full_q <= 1'b1;
		else if (release_slot)
			full_q <= 1'b0;
	end

	// Payload only loads on acceptance, held until the slot empties
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			addr_q <= in_addr;
			len_q  <= in_len;
			size_q <= in_size;
			id_q   <= in_id;
		end
	end

	assign req.full = full_q;	// Request seen by the policy
	assign req.addr = addr_q;
	assign req.len  = len_q;
	assign req.size = size_q;
	assign req.id   = id_q;

	assign out_addr = addr_q;	// Same register feeds downstream
	assign out_len  = len_q;
	assign out_size = size_q;
	assign out_id   = id_q;

	// Stalled forward request must hold
	a_fwd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_addr))
		else $error("addr_slot: forward request changed under back-pressure");

	// Denied request leaves after its one cycle
	a_deny_drop: assert property (@(posedge clk) disable iff (!rst_n)
		req.full && !req.allow |=> in_ready)
		else $error("addr_slot: denied request not dropped");

endmodule

//--- addr_req_if.sv
// Held address request and its verdict, one instance per channel
// The slot drives the request and the policy answers with allow in the same cycle

`timescale 1ns/1ps

interface addr_req_if #(
	parameter int unsigned ADDR_WIDTH = 32	// Request address width
);
	import noc_guard_pkg::*;

	logic                  full;	// Slot holds a request
	logic [ADDR_WIDTH-1:0] addr;	// Held address
	len_t                  len;	// Held burst length
	size_t                 size;	// Held burst size
	id_t                   id;	// Held transaction ID
	logic                  allow;	// Verdict, valid while full

	modport slot (
		output full, addr, len, size, id,
		input  allow
	);

	modport policy (
		input  full, addr, len, size, id,
		output allow
	);

endinterface

//--- noc_guard_pkg.sv
// Shared field types, permission encoding and region codes for the access guard
// Imported by the address request interface and the guard modules

package noc_guard_pkg;

	// AXI address channel fields kept by the guard
	typedef logic [3:0] len_t;	// Burst length, beats minus one
	typedef logic [2:0] size_t;	// Burst size code
	typedef logic [3:0] id_t;	// Transaction ID

	// Region select from the top address bits
	localparam int unsigned REGION_BITS = 2;

	localparam logic [REGION_BITS-1:0] REGION_OPEN0  = 2'd0;	// Read and write
	localparam logic [REGION_BITS-1:0] REGION_OPEN1  = 2'd1;	// Read and write
	localparam logic [REGION_BITS-1:0] REGION_RDONLY = 2'd2;	// Writes denied
	localparam logic [REGION_BITS-1:0] REGION_LOCKED = 2'd3;	// All access denied

	// Permission result of the region decode
	// Bit 1 is the write deny, bit 0 the read deny, as on the old APU output
	typedef struct packed {
		logic write_deny;	// Region refuses writes
		logic read_deny;	// Region refuses reads
	} perm_t;

	// Denial counter, saturates at all ones
	localparam int unsigned DENY_CNT_WIDTH = 8;

endpackage
